// File: design/core_pkg.sv
package core_pkg;

  // the ISA fixes the data width
  localparam int XLEN = 32;

  // request toward memory, held steady until ack
  typedef struct packed {
    logic            valid;
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [3:0]      wstrb;
  } mem_req_t;

  // ack is a single-cycle pulse, rdata valid with it
  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXECUTE,
    S_MEMORY,
    S_WRITEBACK,
    S_HALT
  } ctrl_state_e;

  typedef struct packed {
    opcode_e         opcode;
    alu_op_e         alu_op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;
    logic [2:0]      func3;
    logic            use_imm;
    logic            reg_write;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            is_jump;
    logic            is_halt;
    logic            is_illegal;
  } decoded_t;

endpackage

// File: design/core_control.sv
`timescale 1ns/1ps

module core_control import core_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     mem_done,
  input  decoded_t dec,
  output logic     fetch_start,
  output logic     decode_en,
  output logic     exec_en,
  output logic     mem_start,
  output logic     wb_en,
  output logic     halt
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  // set once the bus transfer of the current phase has been started
  logic        issued_q;
  logic        stop;

  assign stop = dec.is_halt | dec.is_illegal;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_FETCH: begin
        if (mem_done) begin
          state_d = S_DECODE;
        end
      end
      S_DECODE: begin
        state_d = S_EXECUTE;
      end
      S_EXECUTE: begin
        // only loads and stores need the memory phase
        if (dec.is_load || dec.is_store) begin
          state_d = S_MEMORY;
        end else begin
          state_d = S_WRITEBACK;
        end
      end
      S_MEMORY: begin
        if (mem_done) begin
          state_d = S_WRITEBACK;
        end
      end
      S_WRITEBACK: begin
        state_d = stop ? S_HALT : S_FETCH;
      end
      default: begin
        state_d = S_HALT;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q  <= S_FETCH;
      issued_q <= 1'b0;
      halt     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (fetch_start || mem_start) begin
        issued_q <= 1'b1;
      end else if (mem_done) begin
        issued_q <= 1'b0;
      end
      // sticky until reset
      if (state_q == S_WRITEBACK && stop) begin
        halt <= 1'b1;
      end
    end
  end

  // start strobes fire in the first cycle of their phase
  assign fetch_start = (state_q == S_FETCH) && !issued_q;
  assign mem_start   = (state_q == S_MEMORY) && !issued_q;
  assign decode_en   = (state_q == S_DECODE);
  assign exec_en     = (state_q == S_EXECUTE);
  assign wb_en       = (state_q == S_WRITEBACK);

endmodule

// File: design/inst_decode.sv
`timescale 1ns/1ps

module inst_decode import core_pkg::*; #(
  parameter int NREGS = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            capture,
  input  logic [XLEN-1:0] word,
  output decoded_t        dec
);

  localparam logic [XLEN-1:0] NOP    = 32'h0000_0013;
  localparam logic [XLEN-1:0] EBREAK = 32'h0010_0073;

  logic [XLEN-1:0] inst_q;
  logic [6:0]      func7;
  logic            uses_rs1;
  logic            uses_rs2;
  logic            bad_enc;
  logic            chk_func7;
  logic            alt_ok;

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_q <= NOP;
    end else if (capture) begin
      inst_q <= word;
    end
  end

  assign func7 = inst_q[31:25];

  always_comb begin
    dec          = '0;
    dec.opcode   = opcode_e'(inst_q[6:0]);
    dec.alu_op   = ALU_ADD;
    dec.rd       = inst_q[11:7];
    dec.rs1      = inst_q[19:15];
    dec.rs2      = inst_q[24:20];
    dec.func3    = inst_q[14:12];
    dec.imm      = {{20{inst_q[31]}}, inst_q[31:20]};
    uses_rs1     = 1'b0;
    uses_rs2     = 1'b0;
    bad_enc      = 1'b0;
    // func7 matters for register ops and immediate shifts
    chk_func7    = (dec.opcode == OP_REG) || (dec.func3[1:0] == 2'b01);
    alt_ok       = (dec.func3 == 3'b101) || (dec.func3 == 3'b000 && dec.opcode == OP_REG);
    case (dec.opcode)
      OP_IMM, OP_REG: begin
        dec.use_imm   = (dec.opcode == OP_IMM);
        dec.reg_write = 1'b1;
        uses_rs1      = 1'b1;
        uses_rs2      = (dec.opcode == OP_REG);
        case (dec.func3)
          3'b000:  dec.alu_op = (dec.opcode == OP_REG && func7[5]) ? ALU_SUB : ALU_ADD;
          3'b001:  dec.alu_op = ALU_SLL;
          3'b010:  dec.alu_op = ALU_SLT;
          3'b011:  dec.alu_op = ALU_SLTU;
          3'b100:  dec.alu_op = ALU_XOR;
          3'b101:  dec.alu_op = func7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  dec.alu_op = ALU_OR;
          default: dec.alu_op = ALU_AND;
        endcase
        bad_enc = chk_func7 && (((func7 & 7'b1011111) != 7'd0) || (func7[5] && !alt_ok));
      end
      OP_LUI: begin
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.alu_op    = ALU_PASS_B;
        dec.imm       = {inst_q[31:12], 12'd0};
      end
      OP_AUIPC: begin
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm       = {inst_q[31:12], 12'd0};
      end
      OP_JAL: begin
        dec.is_jump   = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm       = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                         inst_q[30:21], 1'b0};
      end
      OP_JALR: begin
        dec.is_jump   = 1'b1;
        dec.reg_write = 1'b1;
        uses_rs1      = 1'b1;
        bad_enc       = (dec.func3 != 3'b000);
      end
      OP_BRANCH: begin
        dec.is_branch = 1'b1;
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        dec.imm       = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                         inst_q[11:8], 1'b0};
        // beq bne blt bge only
        bad_enc       = dec.func3[1];
      end
      OP_LOAD: begin
        dec.is_load   = 1'b1;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        uses_rs1      = 1'b1;
        bad_enc       = (dec.func3 != 3'b010);
      end
      OP_STORE: begin
        dec.is_store  = 1'b1;
        dec.use_imm   = 1'b1;
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        dec.imm       = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
        bad_enc       = (dec.func3 != 3'b010);
      end
      OP_SYSTEM: begin
        dec.is_halt   = (inst_q == EBREAK);
        bad_enc       = (inst_q != EBREAK);
      end
      default: begin
        bad_enc       = 1'b1;
      end
    endcase
    dec.is_illegal = bad_enc || (dec.reg_write && dec.rd >= NREGS) ||
                     (uses_rs1 && dec.rs1 >= NREGS) || (uses_rs2 && dec.rs2 >= NREGS);
    // an illegal word must not touch registers or memory
    if (dec.is_illegal) begin
      dec.reg_write = 1'b0;
      dec.is_load   = 1'b0;
      dec.is_store  = 1'b0;
    end
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; #(
  parameter int NREGS = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  logic [4:0]      raddr1,
  input  logic [4:0]      raddr2,
  input  logic [4:0]      waddr,
  input  logic [XLEN-1:0] wdata,
  input  logic            wen,
  output logic [XLEN-1:0] rdata1,
  output logic [XLEN-1:0] rdata2
);

  localparam int AW = $clog2(NREGS);

  logic [XLEN-1:0] regs [NREGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0 && waddr < NREGS) begin
      regs[waddr[AW-1:0]] <= wdata;
    end
  end

  // x0 and out-of-range indices read as zero
  assign rdata1 = (raddr1 == 5'd0 || raddr1 >= NREGS) ? '0 : regs[raddr1[AW-1:0]];
  assign rdata2 = (raddr2 == 5'd0 || raddr2 >= NREGS) ? '0 : regs[raddr2[AW-1:0]];

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
  input  logic            clock,
  input  logic            exec_en,
  input  decoded_t        dec,
  input  logic [XLEN-1:0] src1,
  input  logic [XLEN-1:0] src2,
  input  logic [XLEN-1:0] pc,
  output logic [XLEN-1:0] result,
  output logic [XLEN-1:0] next_pc
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] target;
  logic [4:0]      shamt;
  logic            pc_rel;
  logic            taken;

  // link value pc+4 for jumps comes out of the adder
  assign pc_rel = (dec.opcode == OP_AUIPC) || (dec.opcode == OP_JAL) ||
                  (dec.opcode == OP_JALR);
  assign op_a   = pc_rel ? pc : src1;
  assign op_b   = dec.use_imm ? dec.imm : (dec.is_jump ? 32'd4 : src2);
  assign shamt  = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_SLL:    alu_out = op_a << shamt;
      ALU_SRL:    alu_out = op_a >> shamt;
      ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // branch condition on the raw register operands
  always_comb begin
    case (dec.func3)
      3'b000:  taken = (src1 == src2);
      3'b001:  taken = (src1 != src2);
      3'b100:  taken = $signed(src1) < $signed(src2);
      3'b101:  taken = $signed(src1) >= $signed(src2);
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = src1 + dec.imm;
  assign target   = (dec.opcode == OP_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc + dec.imm;

  always_ff @(posedge clock) begin
    if (exec_en) begin
      result  <= alu_out;
      next_pc <= (dec.is_jump || (dec.is_branch && taken)) ? target : pc + 32'd4;
    end
  end

endmodule

// File: design/mem_access.sv
`timescale 1ns/1ps

module mem_access import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            fetch_start,
  input  logic            mem_start,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] addr,
  input  logic [XLEN-1:0] wdata,
  input  logic            store,
  input  mem_rsp_t        bus_rsp,
  output mem_req_t        bus_req,
  output logic [XLEN-1:0] rdata,
  output logic            mem_done
);

  mem_req_t req_q;

  // transfer ends in the ack cycle
  assign mem_done = req_q.valid & bus_rsp.ack;

  always_ff @(posedge clock) begin
    if (reset) begin
      req_q <= '0;
    end else if (fetch_start) begin
      req_q.valid <= 1'b1;
      req_q.write <= 1'b0;
      req_q.addr  <= {pc[XLEN-1:2], 2'b00};
      req_q.wdata <= '0;
      req_q.wstrb <= 4'h0;
    end else if (mem_start) begin
      req_q.valid <= 1'b1;
      req_q.write <= store;
      req_q.addr  <= {addr[XLEN-1:2], 2'b00};
      req_q.wdata <= store ? wdata : '0;
      // word stores only
      req_q.wstrb <= store ? 4'hf : 4'h0;
    end else if (mem_done) begin
      req_q.valid <= 1'b0;
    end
  end

  // load data held for writeback
  always_ff @(posedge clock) begin
    if (mem_done) begin
      rdata <= bus_rsp.rdata;
    end
  end

  assign bus_req = req_q;

endmodule

// File: design/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
  parameter int              NREGS    = 16,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic     clock,
  input  logic     reset,
  output mem_req_t bus_req,
  input  mem_rsp_t bus_rsp,
  output logic     halt
);

  decoded_t        dec;
  logic            fetch_start;
  logic            decode_en;
  logic            exec_en;
  logic            mem_start;
  logic            wb_en;
  logic            mem_done;
  logic            fetch_phase;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic [XLEN-1:0] src1_q;
  logic [XLEN-1:0] src2_q;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] wb_data;

  core_control u_control (
    .clock       (clock),
    .reset       (reset),
    .mem_done    (mem_done),
    .dec         (dec),
    .fetch_start (fetch_start),
    .decode_en   (decode_en),
    .exec_en     (exec_en),
    .mem_start   (mem_start),
    .wb_en       (wb_en),
    .halt        (halt)
  );

  // marks an instruction fetch on the shared port
  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_phase <= 1'b0;
    end else if (fetch_start) begin
      fetch_phase <= 1'b1;
    end else if (mem_done) begin
      fetch_phase <= 1'b0;
    end
  end

  inst_decode #(.NREGS(NREGS)) u_decode (
    .clock   (clock),
    .reset   (reset),
    .capture (mem_done & fetch_phase),
    .word    (bus_rsp.rdata),
    .dec     (dec)
  );

  reg_file #(.NREGS(NREGS)) u_regs (
    .clock  (clock),
    .reset  (reset),
    .raddr1 (dec.rs1),
    .raddr2 (dec.rs2),
    .waddr  (dec.rd),
    .wdata  (wb_data),
    .wen    (wb_en & dec.reg_write),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  // operands sampled in the decode cycle
  always_ff @(posedge clock) begin
    if (decode_en) begin
      src1_q <= rdata1;
      src2_q <= rdata2;
    end
  end

  alu u_alu (
    .clock   (clock),
    .exec_en (exec_en),
    .dec     (dec),
    .src1    (src1_q),
    .src2    (src2_q),
    .pc      (pc_q),
    .result  (alu_result),
    .next_pc (next_pc)
  );

  mem_access u_mem (
    .clock       (clock),
    .reset       (reset),
    .fetch_start (fetch_start),
    .mem_start   (mem_start),
    .pc          (pc_q),
    .addr        (alu_result),
    .wdata       (src2_q),
    .store       (dec.is_store),
    .bus_rsp     (bus_rsp),
    .bus_req     (bus_req),
    .rdata       (load_data),
    .mem_done    (mem_done)
  );

  assign wb_data = dec.is_load ? load_data : alu_result;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= RESET_PC;
    end else if (wb_en) begin
      pc_q <= next_pc;
    end
  end

endmodule

// File: tests/core_asserts.sv
`timescale 1ns/1ps

module core_asserts import core_pkg::*; (
  input logic     clock,
  input logic     reset,
  input mem_req_t bus_req,
  input mem_rsp_t bus_rsp,
  input logic     halt,
  input logic     fetch_start,
  input logic     mem_start
);

  // request held until the memory answers
  req_stable: assert property (@(posedge clock) disable iff (reset)
    bus_req.valid && !bus_rsp.ack |=> bus_req.valid && $stable(bus_req))
    else $error("bus_req changed before ack");

  drop_after_ack: assert property (@(posedge clock) disable iff (reset)
    bus_req.valid && bus_rsp.ack |=> !bus_req.valid)
    else $error("bus_req.valid still high after ack");

  halt_sticky: assert property (@(posedge clock) disable iff (reset)
    halt |=> halt)
    else $error("halt fell before reset");

  no_req_halted: assert property (@(posedge clock) disable iff (reset)
    halt |-> !$rose(bus_req.valid))
    else $error("request raised while halted");

  // start strobes only when the port is idle
  start_idle: assert property (@(posedge clock) disable iff (reset)
    fetch_start || mem_start |-> !bus_req.valid)
    else $error("start strobe while a transfer is pending");

endmodule

bind core_top core_asserts u_asserts (
  .clock       (clock),
  .reset       (reset),
  .bus_req     (bus_req),
  .bus_rsp     (bus_rsp),
  .halt        (halt),
  .fetch_start (fetch_start),
  .mem_start   (mem_start)
);

// File: tests/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

  localparam int          NREGS            = 16;
  localparam int          MEM_WORDS        = 1024;
  localparam int          BODY_OPS         = 48;
  localparam int          POST_HALT_CYCLES = 64;
  localparam logic [31:0] SEED             = 32'hd614;

  logic     clock   = 1'b0;
  logic     reset   = 1'b1;
  mem_rsp_t bus_rsp = '0;
  mem_req_t bus_req;
  logic     halt;

  logic [31:0] prog_mem [MEM_WORDS];
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] exp_rd_addr [$];
  logic [31:0] exp_st_addr [$];
  logic [31:0] exp_st_data [$];
  logic [31:0] gen_lfsr    = SEED;
  logic [31:0] lat_lfsr    = SEED;
  logic [1:0]  wait_cnt    = 2'd0;
  bit          busy        = 1'b0;
  bit          exp_halt    = 1'b0;
  bit          model_ready = 1'b0;
  bit          started     = 1'b0;
  bit          halt_seen   = 1'b0;
  int          code_len    = 0;
  int          n_exec      = 0;
  int          rd_idx      = 0;
  int          st_idx      = 0;
  int          idle_cycles = 0;
  int          checks      = 0;
  int          errors      = 0;

  core_top #(.NREGS(NREGS), .RESET_PC(32'h0)) DUT (
    .clock   (clock),
    .reset   (reset),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .halt    (halt)
  );

  always #50 clock = ~clock;

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] lfsr_bits(inout logic [31:0] state, input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
      state = {state[30:0], fb};
      bits  = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic emit_word(input logic [31:0] w);
    prog_mem[code_len] = w;
    code_len++;
  endtask

  // one register, immediate or upper-immediate op
  task automatic add_random_op();
    logic [1:0] kind;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] shamt;
    logic       alt;
    kind  = 2'(lfsr_bits(gen_lfsr, 2));
    f3    = 3'(lfsr_bits(gen_lfsr, 3));
    rd    = 5'(lfsr_bits(gen_lfsr, 4));
    rs1   = 5'(lfsr_bits(gen_lfsr, 4));
    rs2   = 5'(lfsr_bits(gen_lfsr, 4));
    shamt = 5'(lfsr_bits(gen_lfsr, 5));
    alt   = 1'(lfsr_bits(gen_lfsr, 1));
    case (kind)
      2'd0, 2'd1: emit_word(rtype({1'b0, alt & (f3 == 3'd0 || f3 == 3'd5), 5'd0},
                                  rs2, rs1, f3, rd));
      2'd2: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          emit_word(itype({1'b0, alt & (f3 == 3'd5), 5'd0, shamt}, rs1, f3, rd, 7'h13));
        end else begin
          emit_word(itype(12'(lfsr_bits(gen_lfsr, 12)), rs1, f3, rd, 7'h13));
        end
      end
      default: emit_word({20'(lfsr_bits(gen_lfsr, 20)), rd, alt ? 7'h17 : 7'h37});
    endcase
  endtask

  task automatic gen_program();
    logic [2:0] kind;
    logic [1:0] sel;
    logic [4:0] rd;
    logic [4:0] rb;
    int         skip;
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog_mem[i] = 32'(i) * 32'h9e37_79b9;
    end
    for (int r = 1; r < NREGS; r++) begin
      emit_word({20'(lfsr_bits(gen_lfsr, 20)), 5'(r), 7'h37});
      emit_word(itype(12'(lfsr_bits(gen_lfsr, 12)), 5'(r), 3'b000, 5'(r), 7'h13));
    end
    repeat (BODY_OPS) begin
      kind = 3'(lfsr_bits(gen_lfsr, 3));
      sel  = 2'(lfsr_bits(gen_lfsr, 2));
      rd   = 5'(lfsr_bits(gen_lfsr, 4));
      rb   = 5'(lfsr_bits(gen_lfsr, 4));
      skip = 1 + int'(lfsr_bits(gen_lfsr, 1));
      case (kind)
        // beq bne blt bge forward over the next run
        3'd3: emit_word(btype(13'(4 * (skip + 1)), rb, rd, {sel[1], 1'b0, sel[0]}));
        3'd4: emit_word(jtype(21'(4 * (skip + 1)), rd));
        3'd5: begin
          rb = rb | 5'd1;
          emit_word(itype(12'(4 * (code_len + 2 + skip)), 5'd0, 3'b000, rb, 7'h13));
          emit_word(itype(12'd0, rb, 3'b000, rd, 7'h67));
        end
        3'd6: begin
          emit_word(stype(12'h600 + 12'(4 * lfsr_bits(gen_lfsr, 5)), rd, 5'd0));
          skip = 0;
        end
        3'd7: begin
          emit_word(itype(12'h600 + 12'(4 * lfsr_bits(gen_lfsr, 5)), 5'd0, 3'b010, rd,
                          7'h03));
          skip = 0;
        end
        default: skip = 1;
      endcase
      repeat (skip) add_random_op();
    end
    // dump every register including x0
    for (int r = 0; r < NREGS; r++) begin
      emit_word(stype(12'h700 + 12'(4 * r), 5'(r), 5'd0));
    end
    emit_word(32'h0010_0073);
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $unsigned($signed(a) >>> b[4:0]);
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // ISA-level interpreter that fills the expected read and store sequences
  function automatic bit run_model(output int steps);
    logic [31:0] m [MEM_WORDS];
    logic [31:0] x [NREGS];
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] res;
    logic        wen;
    logic        take_br;
    m = prog_mem;
    for (int r = 0; r < NREGS; r++) begin
      x[r] = '0;
    end
    pc    = 32'h0;
    steps = 0;
    while (steps < 4000) begin
      steps++;
      exp_rd_addr.push_back(pc);
      w       = m[pc[11:2]];
      a       = x[w[18:15]];
      b       = x[w[23:20]];
      imm_i   = {{20{w[31]}}, w[31:20]};
      pc_next = pc + 32'd4;
      res     = '0;
      wen     = 1'b1;
      case (w[6:0])
        7'h13: res = alu_ref(w[14:12], w[30] & (w[14:12] == 3'd5), a, imm_i);
        7'h33: res = alu_ref(w[14:12], w[30], a, b);
        7'h37: res = {w[31:12], 12'd0};
        7'h17: res = pc + {w[31:12], 12'd0};
        7'h6f: begin
          res     = pc + 32'd4;
          pc_next = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        7'h67: begin
          res     = pc + 32'd4;
          pc_next = (a + imm_i) & ~32'd1;
        end
        7'h63: begin
          wen = 1'b0;
          case (w[14:12])
            3'd0:    take_br = (a == b);
            3'd1:    take_br = (a != b);
            3'd4:    take_br = $signed(a) < $signed(b);
            default: take_br = $signed(a) >= $signed(b);
          endcase
          if (take_br) begin
            pc_next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        7'h03: begin
          addr = a + imm_i;
          exp_rd_addr.push_back(addr);
          res = m[addr[11:2]];
        end
        7'h23: begin
          wen  = 1'b0;
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          m[addr[11:2]] = b;
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(b);
        end
        7'h73: return 1'b1;
        default: return 1'b0;
      endcase
      if (wen && w[10:7] != 4'd0) begin
        x[w[10:7]] = res;
      end
      pc = pc_next;
    end
    return 1'b0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  initial begin
    gen_program();
    exp_halt    = run_model(n_exec);
    model_ready = 1'b1;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
  end

  // memory with 1 to 4 cycles of ack latency
  always @(posedge clock) begin
    #1;
    if (reset) begin
      mem     = prog_mem;
      busy    = 1'b0;
      bus_rsp = '0;
    end else if (bus_rsp.ack) begin
      bus_rsp.ack = 1'b0;
      busy        = 1'b0;
    end else if (bus_req.valid) begin
      if (!busy) begin
        busy     = 1'b1;
        wait_cnt = 2'(lfsr_bits(lat_lfsr, 2));
      end else if (wait_cnt != 2'd0) begin
        wait_cnt = wait_cnt - 2'd1;
      end else begin
        bus_rsp.ack = 1'b1;
        if (bus_req.write) begin
          mem[bus_req.addr[11:2]] = bus_req.wdata;
        end else begin
          bus_rsp.rdata = mem[bus_req.addr[11:2]];
        end
      end
    end
  end

  always @(negedge clock) begin
    if (!reset) begin
      if (!started) begin
        started = 1'b1;
        check_value("bus_req.valid", 32'h0, 32'(bus_req.valid));
        check_value("halt", 32'h0, 32'(halt));
      end
      if (bus_req.valid && bus_rsp.ack) begin
        if (!bus_req.write) begin
          if (rd_idx < exp_rd_addr.size()) begin
            check_value("bus_req.addr (read)", exp_rd_addr[rd_idx], bus_req.addr);
          end else begin
            errors++;
            $display("read request beyond the end of the reference sequence");
          end
          rd_idx++;
        end else begin
          if (st_idx < exp_st_addr.size()) begin
            check_value("bus_req.addr (store)", exp_st_addr[st_idx], bus_req.addr);
            check_value("bus_req.wdata", exp_st_data[st_idx], bus_req.wdata);
            check_value("bus_req.wstrb", 32'hf, 32'(bus_req.wstrb));
          end else begin
            errors++;
            $display("store request beyond the end of the reference sequence");
          end
          st_idx++;
        end
      end
      if (halt_seen) begin
        if (!halt) begin
          errors++;
          $display("halt fell after it had been raised");
        end
        if (bus_req.valid) begin
          errors++;
          $display("memory request issued while the core is halted");
        end
        idle_cycles++;
        if (idle_cycles == POST_HALT_CYCLES) begin
          check_value("read count", 32'(exp_rd_addr.size()), 32'(rd_idx));
          check_value("store count", 32'(exp_st_addr.size()), 32'(st_idx));
          if (!exp_halt) begin
            errors++;
            $display("reference model ended without reaching ebreak");
          end
          $display("checks: %0d, errors: %0d", checks, errors);
          if (errors == 0) begin
            $display("No errors");
          end else begin
            $display("Errors found");
          end
          $finish;
        end
      end else if (halt) begin
        halt_seen = 1'b1;
      end
    end
  end

  // 8x margin over 12 cycles per executed instruction
  initial begin
    wait (model_ready);
    #(real'(n_exec) * 8.0 * 12.0 * 100.0);
    $display("timeout: the core did not finish the program in time");
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Errors found");
    $finish;
  end

endmodule

// File: sim.f
design/core_pkg.sv
design/core_control.sv
design/inst_decode.sv
design/reg_file.sv
design/alu.sv
design/mem_access.sv
design/core_top.sv
tests/core_asserts.sv
tests/core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module core_tb -Mdir obj_dir -o core_sim -f sim.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi
./obj_dir/core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if grep -qx "No errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL: pass message not found in sim.log"
exit 1
